//--- wt_cache.f
+incdir+logic
logic/wt_cache_pkg.sv
logic/cache_front_end.sv
logic/cache_memory.sv
logic/cache_control.sv
logic/wt_cache.sv
tb/wt_cache_tb.sv

//--- Makefile
SIM  := obj_dir/Vwt_cache_tb
SRCS := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: run clean

$(SIM): wt_cache.f $(SRCS)
	verilator --binary --timing --assert -f wt_cache.f --top-module wt_cache_tb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/wt_cache_golden.txt
# name op ctrl addr wdata wstrb expected_rdata
# hex fields; ctrl 1 selects the counter block, expected is ignored on writes
rd_miss       r 0 00000010 00000000 0 a1a1a1a1
rd_hit        r 0 00000010 00000000 0 a1a1a1a1
wr_part_hit   w 0 00000010 11223344 3 00000000
rd_merged     r 0 00000010 00000000 0 a1a13344
wr_no_alloc   w 0 00000024 deadbeef f 00000000
rd_no_alloc   r 0 00000024 00000000 0 deadbeef
rd_evict_a    r 0 00000050 00000000 0 b1b1b1b1
rd_evict_b    r 0 00000010 00000000 0 a1a13344
rd_evict_a2   r 0 00000050 00000000 0 b1b1b1b1
wr_evicted    w 0 00000010 cafef00d c 00000000
rd_evict_b2   r 0 00000010 00000000 0 cafe3344
cnt_read_hit  r 1 00000000 00000000 0 00000002
cnt_read_miss r 1 00000004 00000000 0 00000006
cnt_write_hit r 1 00000008 00000000 0 00000001
cnt_write_mis r 1 0000000c 00000000 0 00000002
cnt_clear     w 1 00000004 00000000 f 00000000
cnt_rd_hit_0  r 1 00000000 00000000 0 00000000
cnt_rd_miss_0 r 1 00000004 00000000 0 00000000
rd_cached     r 0 00000024 00000000 0 deadbeef
invalidate    w 1 00000000 00000000 f 00000000
rd_after_inv  r 0 00000024 00000000 0 deadbeef
cnt_rd_miss_1 r 1 00000004 00000000 0 00000001
cnt_rd_hit_1  r 1 00000000 00000000 0 00000001

//--- tb/wt_cache_tb.sv
`include "wt_cache_consts.svh"

module wt_cache_tb
   import wt_cache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT   = 200;  // cycles per ready wait
   localparam int MEM_WORDS = 256;
   localparam int N_LINES   = 1 << `CACHE_LINE_W;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     valid;
   cache_addr_u              addr;
   logic [`CACHE_DATA_W-1:0] wdata;
   logic [`CACHE_NBYTES-1:0] wstrb;
   logic [`CACHE_DATA_W-1:0] rdata;
   logic                     ready;
   logic                     mem_valid;
   logic [`CACHE_ADDR_W-1:0] mem_addr;
   logic [`CACHE_DATA_W-1:0] mem_wdata;
   logic [`CACHE_NBYTES-1:0] mem_wstrb;
   logic [`CACHE_DATA_W-1:0] mem_rdata = '0;
   logic                     mem_ready = 1'b0;

   logic [`CACHE_DATA_W-1:0] mem_model [0:MEM_WORDS-1];
   logic [31:0]              lcg_state;
   int                       mem_delay;   // cycles left before mem_ready
   logic                     mem_busy;
   logic                     line_valid [0:N_LINES-1];  // expected cache tags
   logic [`CACHE_TAG_W-1:0]  line_tag   [0:N_LINES-1];
   int                       errors;
   int                       checks;

   wt_cache u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   always #10 clk = ~clk;  // 20 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check(input logic [8*24-1:0] name, input string what,
                        input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("mismatch %0s %0s: expected %h, actual %h", name, what, expected, actual);
         errors++;
      end
   endtask

   ////////////////////
   // memory model
   ////////////////////

   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         lcg_state = 32'h5447cb1e;
         mem_busy  = 1'b0;
         mem_ready <= 1'b0;
         for (int i = 0; i < MEM_WORDS; i++)
            mem_model[i] = i * 32'h01010101 ^ 32'hA5A5A5A5;  // fill by word address
      end
      else if (mem_ready)
         mem_ready <= 1'b0;  // request done, mem_valid drops
      else if (mem_valid)
      begin
         if (!mem_busy)
         begin
            mem_busy  = 1'b1;
            mem_delay = int'(lcg_next() >> 16) % 6;  // 0 to 5 cycles
         end
         if (mem_delay == 0)
         begin
            for (int b = 0; b < `CACHE_NBYTES; b++)
               if (mem_wstrb[b])
                  mem_model[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
            mem_rdata <= mem_model[mem_addr[9:2]];
            mem_ready <= 1'b1;
            mem_busy  = 1'b0;
         end
         else
            mem_delay--;
      end
   end

   ////////////////////
   // golden replay
   ////////////////////

   initial
   begin
      int                       fd;
      int                       code;
      int                       cycles;
      int                       flag;
      logic [8*128-1:0]         line;
      logic [8*24-1:0]          name;
      logic [7:0]               op;
      logic [31:0]              a;
      logic [31:0]              wd;
      logic [31:0]              ws;
      logic [31:0]              expd;
      logic [`CACHE_LINE_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0]  tag;
      logic                     hit;
      logic                     stop;

      errors = 0;
      checks = 0;
      stop   = 1'b0;
      rst_n  = 1'b0;
      valid  = 1'b0;
      addr   = '0;
      wdata  = '0;
      wstrb  = '0;
      for (int i = 0; i < N_LINES; i++)
         line_valid[i] = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      fd = $fopen("tb/wt_cache_golden.txt", "r");
      if (fd == 0)
      begin
         $display("error: cannot open tb/wt_cache_golden.txt");
         errors++;
         stop = 1'b1;
      end
      while (!stop && !$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code > 0)
            code = $sscanf(line, "%s %s %d %h %h %h %h", name, op, flag, a, wd, ws, expd);
         if (code == 7)  // comment lines never give 7 fields
         begin
            idx = a[`CACHE_BYTE_W +: `CACHE_LINE_W];
            tag = a[31 -: `CACHE_TAG_W];
            hit = (flag == 0) && (op == "r") && line_valid[idx] && (line_tag[idx] == tag);
            valid = 1'b1;  // we sit on a falling edge here
            addr  = {flag[0], a};
            wdata = wd;
            wstrb = ws[`CACHE_NBYTES-1:0];
            cycles = 0;
            do
            begin
               @(posedge clk);
               @(negedge clk);
               cycles++;
            end while (!ready && cycles < TIMEOUT);
            if (!ready)
            begin
               $display("error: no ready from cache for %0s within %0d cycles", name, TIMEOUT);
               errors++;
               valid = 1'b0;
               stop  = 1'b1;
            end
            else
            begin
               if (op == "r")
                  check(name, "rdata", expd, rdata);
               if (op == "r" && flag == 0)
                  check(name, "memory word", expd, mem_model[a[9:2]]);  // write-through
               if (flag != 0 || hit)
                  check(name, "latency", 32'd2, cycles);
               // reads allocate on miss, writes never do
               if (flag == 0 && op == "r" && !hit)
               begin
                  line_valid[idx] = 1'b1;
                  line_tag[idx]   = tag;
               end
               if (flag != 0 && op == "w" && a[3:2] == 2'd0)
                  for (int i = 0; i < N_LINES; i++)
                     line_valid[i] = 1'b0;  // invalidate all
               @(negedge clk);
               valid = 1'b0;  // cycle after ready
            end
         end
      end
      if (fd != 0)
         $fclose(fd);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- logic/wt_cache.sv
`include "wt_cache_consts.svh"

module wt_cache
   import wt_cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   // master port
   input  logic                     valid,
   input  cache_addr_u              addr,       // msb selects the controller
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ready,
   // memory port, native
   output logic                     mem_valid,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic [`CACHE_DATA_W-1:0] mem_wdata,
   output logic [`CACHE_NBYTES-1:0] mem_wstrb,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     mem_ready
);

   ////////////////////
   // internal wiring
   ////////////////////

   cache_req_t               req;           // stored request, to both blocks
   logic                     cache_valid;
   logic                     cache_ready;
   logic [`CACHE_DATA_W-1:0] cache_rdata;
   logic                     ctrl_valid;
   logic                     ctrl_ready;
   logic [`CACHE_DATA_W-1:0] ctrl_rdata;
   cache_events_t            events;        // hit/miss pulses
   logic                     invalidate;
   mem_req_t                 mem_req;

   cache_front_end cache_front_end (
      .clk         (clk),
      .rst_n       (rst_n),
      .valid       (valid),
      .addr        (addr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata       (rdata),
      .ready       (ready),
      .cache_valid (cache_valid),
      .req         (req),
      .cache_rdata (cache_rdata),
      .cache_ready (cache_ready),
      .ctrl_valid  (ctrl_valid),
      .ctrl_rdata  (ctrl_rdata),
      .ctrl_ready  (ctrl_ready)
   );

   cache_memory cache_memory (
      .clk        (clk),
      .rst_n      (rst_n),
      .valid      (cache_valid),
      .req        (req),
      .invalidate (invalidate),
      .rdata      (cache_rdata),
      .ready      (cache_ready),
      .events     (events),
      .mem_valid  (mem_valid),
      .mem_req    (mem_req),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready)
   );

   cache_control cache_control (
      .clk        (clk),
      .rst_n      (rst_n),
      .valid      (ctrl_valid),
      .req        (req),
      .events     (events),
      .rdata      (ctrl_rdata),
      .ready      (ctrl_ready),
      .invalidate (invalidate)
   );

   // flat memory port
   assign mem_addr  = mem_req.addr;
   assign mem_wdata = mem_req.wdata;
   assign mem_wstrb = mem_req.wstrb;

endmodule

//--- logic/cache_control.sv
`include "wt_cache_consts.svh"

module cache_control
   import wt_cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid,
   input  cache_req_t               req,
   input  cache_events_t            events,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ready,
   output logic                     invalidate
);

   localparam int N_CNT = 1 << `CTRL_REG_W;

   logic [`CACHE_DATA_W-1:0] cnt [0:N_CNT-1];  // indexed like reg_idx
   logic [N_CNT-1:0]         ev_vec;
   logic [`CTRL_REG_W-1:0]   reg_idx;
   logic                     is_write;

   assign reg_idx  = req.addr.ctrl.reg_idx;
   assign is_write = |req.wstrb;

   // bit i counts into cnt[i]
   assign ev_vec = {events.write_miss, events.write_hit, events.read_miss, events.read_hit};

   ////////////////////
   // counters
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ready      <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < N_CNT; i++)
            cnt[i] <= '0;
      end
      else
      begin
         ready      <= valid;
         invalidate <= valid && is_write && (reg_idx == 2'd0);
         if (valid && is_write && (reg_idx == 2'd1))
            for (int i = 0; i < N_CNT; i++)
               cnt[i] <= '0;               // counter clear
         else
            for (int i = 0; i < N_CNT; i++)
               if (ev_vec[i] && (cnt[i] != '1))
                  cnt[i] <= cnt[i] + 1'b1;  // saturate at all ones
      end
   end

   // register read
   always_ff @(posedge clk)
   begin
      if (valid && !is_write)
         rdata <= cnt[reg_idx];
   end

   a_inv_single: assert property (@(posedge clk) disable iff (!rst_n)
      invalidate |=> !invalidate);

endmodule

//--- logic/cache_memory.sv
`include "wt_cache_consts.svh"

module cache_memory
   import wt_cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid,       // one-cycle pulse from front end
   input  cache_req_t               req,         // stable until ready
   input  logic                     invalidate,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ready,
   output cache_events_t            events,
   // memory port
   output logic                     mem_valid,
   output mem_req_t                 mem_req,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     mem_ready
);

   // lookup is done in the idle cycle that sees valid
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_MEM_WAIT,
      ST_RESPOND
   } state_t;

   state_t state;

   ////////////////////
   // arrays
   ////////////////////

   logic [`CACHE_TAG_W-1:0]        tag_mem  [0:(1<<`CACHE_LINE_W)-1];
   logic [`CACHE_DATA_W-1:0]       data_mem [0:(1<<`CACHE_LINE_W)-1];
   logic [(1<<`CACHE_LINE_W)-1:0]  line_valid;  // one bit per line

   logic [`CACHE_LINE_W-1:0] idx;
   logic                     is_write;
   logic                     hit;
   logic                     lookup;
   logic                     fill;     // read miss data back from memory

   assign idx      = req.addr.cache.index;
   assign is_write = |req.wstrb;
   assign hit      = line_valid[idx] && (tag_mem[idx] == req.addr.cache.tag);
   assign lookup   = valid && (state == ST_IDLE);
   assign fill     = (state == ST_MEM_WAIT) && mem_ready && !is_write;

   // one event per access in the lookup cycle
   assign events.read_hit   = lookup && !is_write && hit;
   assign events.read_miss  = lookup && !is_write && !hit;
   assign events.write_hit  = lookup && is_write && hit;
   assign events.write_miss = lookup && is_write && !hit;

   assign ready = (state == ST_RESPOND);

   ////////////////////
   // sequencer
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         mem_valid <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (lookup)
               begin
                  if (hit && !is_write)
                     state <= ST_RESPOND;   // read hit needs no memory trip
                  else
                  begin
                     state     <= ST_MEM_WAIT;  // miss fetch or write-through
                     mem_valid <= 1'b1;
                  end
               end
            ST_MEM_WAIT:
               if (mem_ready)
               begin
                  mem_valid <= 1'b0;
                  state     <= ST_RESPOND;
               end
            default:
               state <= ST_IDLE;  // respond lasts one cycle
         endcase
      end
   end

   // valid bits cleared by reset or control invalidate
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         line_valid <= '0;
      else if (invalidate)
         line_valid <= '0;
      else if (fill)
         line_valid[idx] <= 1'b1;
   end

   // payload regs for memory request, read data and line contents
   always_ff @(posedge clk)
   begin
      if (lookup)
      begin
         mem_req.addr  <= {req.addr.cache.tag, idx, {`CACHE_BYTE_W{1'b0}}};
         mem_req.wdata <= req.wdata;
         mem_req.wstrb <= req.wstrb;  // zero on reads
         rdata         <= data_mem[idx];
         if (is_write && hit)
            for (int b = 0; b < `CACHE_NBYTES; b++)
               if (req.wstrb[b])
                  data_mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];  // strobed merge
      end
      if (fill)
      begin
         rdata         <= mem_rdata;
         data_mem[idx] <= mem_rdata;
         tag_mem[idx]  <= req.addr.cache.tag;
      end
   end

   // each request pulse lands in idle and raises exactly one event
   a_events_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      valid |-> $onehot(events));

   // memory request held under back-pressure
   a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_req)));

endmodule

//--- logic/cache_front_end.sv
`include "wt_cache_consts.svh"

module cache_front_end
   import wt_cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   // master port
   input  logic                     valid,
   input  cache_addr_u              addr,     // msb selects control
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ready,
   // cache memory side
   output logic                     cache_valid,
   output cache_req_t               req,      // shared by both blocks
   input  logic [`CACHE_DATA_W-1:0] cache_rdata,
   input  logic                     cache_ready,
   // cache control side
   output logic                     ctrl_valid,
   input  logic [`CACHE_DATA_W-1:0] ctrl_rdata,
   input  logic                     ctrl_ready
);

   logic busy;    // a request is out at one of the blocks
   logic accept;

   assign accept = valid && !busy;

   ////////////////////
   // request register
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (accept)
         req <= '{addr: addr, wdata: wdata, wstrb: wstrb};
   end

   // one-cycle pulse to the chosen block
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         busy        <= 1'b0;
         cache_valid <= 1'b0;
         ctrl_valid  <= 1'b0;
      end
      else
      begin
         cache_valid <= accept && !addr.cache.ctrl_sel;
         ctrl_valid  <= accept && addr.ctrl.ctrl_sel;
         if (accept)
            busy <= 1'b1;
         else if (ready)
            busy <= 1'b0;  // master may change valid next cycle
      end
   end

   ////////////////////
   // response merge
   ////////////////////

   assign ready = cache_ready || ctrl_ready;  // only one block answers
   assign rdata = req.addr.ctrl.ctrl_sel ? ctrl_rdata : cache_rdata;

   // a block answers only to a request still pending here
   a_no_stray_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (cache_ready || ctrl_ready) |-> busy);

endmodule

//--- logic/wt_cache_pkg.sv
`include "wt_cache_consts.svh"

package wt_cache_pkg;

   // address as seen by the cache memory
   typedef struct packed {
      logic                     ctrl_sel;  // 0 here
      logic [`CACHE_TAG_W-1:0]  tag;
      logic [`CACHE_LINE_W-1:0] index;
      logic [`CACHE_BYTE_W-1:0] byte_off;
   } cache_view_t;

   // same word as seen by the control block
   typedef struct packed {
      logic                                                ctrl_sel;  // 1 here
      logic [`CACHE_ADDR_W-`CTRL_REG_W-`CACHE_BYTE_W-1:0] pad;
      logic [`CTRL_REG_W-1:0]                             reg_idx;
      logic [`CACHE_BYTE_W-1:0]                           byte_off;
   } ctrl_view_t;

   typedef union packed {
      cache_view_t cache;
      ctrl_view_t  ctrl;
   } cache_addr_u;  // 33 bits, msb picks the view

   typedef struct packed {
      cache_addr_u              addr;
      logic [`CACHE_DATA_W-1:0] wdata;
      logic [`CACHE_NBYTES-1:0] wstrb;  // non-zero means write
   } cache_req_t;

   typedef struct packed {
      logic [`CACHE_ADDR_W-1:0] addr;   // word aligned
      logic [`CACHE_DATA_W-1:0] wdata;
      logic [`CACHE_NBYTES-1:0] wstrb;  // zero means read
   } mem_req_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_events_t;

endpackage

//--- logic/wt_cache_consts.svh
`ifndef WT_CACHE_CONSTS_SVH
`define WT_CACHE_CONSTS_SVH

////////////////////
// front-end sizes
////////////////////

`define CACHE_ADDR_W 32   // byte address, selector bit not included
`define CACHE_DATA_W 32   // word width, same on the memory side
`define CACHE_NBYTES 4    // bytes per word
`define CACHE_BYTE_W 2    // byte offset bits

////////////////////
// cache geometry
////////////////////

`define CACHE_LINE_W 4    // index bits, 16 lines of one word
`define CACHE_TAG_W  26   // addr minus index minus byte offset

`define CTRL_REG_W   2    // control register index

`endif
